// File: source/rtc_pkg.sv
/* Calendar fields are packed BCD and the bus uses word addresses.
   Software must write valid BCD values, since the counters do not check them */
package rtc_pkg;

	// Calendar fields
	typedef logic [6:0]  sec_t;   // 00-59
	typedef logic [6:0]  min_t;   // 00-59
	typedef logic [5:0]  hour_t;  // 00-23
	typedef logic [3:0]  day_t;   // Weekday 1-7
	typedef logic [5:0]  date_t;  // 01-31
	typedef logic [4:0]  mon_t;   // 01-12
	typedef logic [15:0] year_t;  // Four digits

	// Bus
	typedef logic [4:0]  wb_adr_t;
	typedef logic [31:0] wb_dat_t;
	typedef logic [3:0]  wb_sel_t;
	typedef logic [31:0] div_t;   // Clock cycles per second

	localparam wb_adr_t ADR_SEC      = 5'h00;
	localparam wb_adr_t ADR_MIN      = 5'h01;
	localparam wb_adr_t ADR_HOUR     = 5'h02;
	localparam wb_adr_t ADR_DAY      = 5'h03;
	localparam wb_adr_t ADR_DATE     = 5'h04;
	localparam wb_adr_t ADR_MON      = 5'h05;
	localparam wb_adr_t ADR_YEAR     = 5'h06;
	localparam wb_adr_t ADR_CON      = 5'h08;
	localparam wb_adr_t ADR_DIV      = 5'h09;
	localparam wb_adr_t ADR_MASK     = 5'h12;
	localparam wb_adr_t ADR_ALM_SEC  = 5'h13;
	localparam wb_adr_t ADR_ALM_MIN  = 5'h14;
	localparam wb_adr_t ADR_ALM_HOUR = 5'h15;
	localparam wb_adr_t ADR_ALM_DAY  = 5'h16;
	localparam wb_adr_t ADR_ALM_DATE = 5'h17;
	localparam wb_adr_t ADR_ALM_MON  = 5'h18;
	localparam wb_adr_t ADR_ALM_YEAR = 5'h19;

	localparam wb_sel_t SEL_BYTE = 4'b0001;
	localparam wb_sel_t SEL_HALF = 4'b0011;  // Year registers
	localparam wb_sel_t SEL_WORD = 4'b1111;  // Divider

	// Control register bits
	localparam int CON_TIME_WE = 0;
	localparam int CON_ALM_WE  = 5;
	localparam int CON_INT_EN  = 6;

	// Bit positions in the calendar write and alarm mask vectors
	localparam int F_SEC  = 0;
	localparam int F_MIN  = 1;
	localparam int F_HOUR = 2;
	localparam int F_DAY  = 3;
	localparam int F_DATE = 4;
	localparam int F_MON  = 5;
	localparam int F_YEAR = 6;

	// Calendar after reset, Saturday 2000-01-01 counted as weekday 1
	localparam sec_t  RST_SEC  = 7'h00;
	localparam min_t  RST_MIN  = 7'h00;
	localparam hour_t RST_HOUR = 6'h00;
	localparam day_t  RST_DAY  = 4'h1;
	localparam date_t RST_DATE = 6'h01;
	localparam mon_t  RST_MON  = 5'h01;
	localparam year_t RST_YEAR = 16'h2000;

endpackage

// File: source/rtc_wb_regs.sv
/* Wishbone slave, no wait states. Ack and err are single pulses, so a master
   holding its strobe gets one termination every other cycle */
`timescale 1ns/1ps

module rtc_wb_regs import rtc_pkg::*; #(
	parameter div_t DIV_RESET = 32'd8
) (
	input  logic       wb_clk_i,
	input  logic       wb_rst_i,
	input  logic       wb_cyc_i,
	input  logic       wb_stb_i,
	input  logic       wb_we_i,
	input  wb_adr_t    wb_adr_i,
	input  wb_sel_t    wb_sel_i,
	input  wb_dat_t    wb_dat_i,
	output wb_dat_t    wb_dat_o,
	output logic       wb_ack_o,
	output logic       wb_err_o,
	input  sec_t       sec_i,
	input  min_t       min_i,
	input  hour_t      hour_i,
	input  day_t       day_i,
	input  date_t      date_i,
	input  mon_t       mon_i,
	input  year_t      year_i,
	output div_t       div_val_o,
	output logic       div_load_o,
	output logic [6:0] cal_we_o,
	output wb_dat_t    cal_wdat_o,
	output sec_t       alm_sec_o,
	output min_t       alm_min_o,
	output hour_t      alm_hour_o,
	output day_t       alm_day_o,
	output date_t      alm_date_o,
	output mon_t       alm_mon_o,
	output year_t      alm_year_o,
	output logic [6:0] alm_mask_o,
	output logic       int_en_o
);

	logic    req_free;  // Request not overlapping a pending pulse
	logic    mapped;
	wb_sel_t sel_exp;
	logic    sel_ok;
	logic    wr;
	logic    time_we;
	logic    alm_we;
	wb_dat_t rd_data;

	// Expected select per register
	always_comb begin
		mapped  = 1'b1;
		sel_exp = SEL_BYTE;
		case (wb_adr_i)
			ADR_YEAR, ADR_ALM_YEAR: sel_exp = SEL_HALF;
			ADR_DIV:                sel_exp = SEL_WORD;
			ADR_SEC, ADR_MIN, ADR_HOUR, ADR_DAY, ADR_DATE, ADR_MON, ADR_CON, ADR_MASK,
			ADR_ALM_SEC, ADR_ALM_MIN, ADR_ALM_HOUR, ADR_ALM_DAY, ADR_ALM_DATE,
			ADR_ALM_MON:            sel_exp = SEL_BYTE;
			default:                mapped = 1'b0;
		endcase
	end

	assign req_free = wb_cyc_i && wb_stb_i && !wb_ack_o && !wb_err_o;
	assign sel_ok   = !mapped || (wb_sel_i == sel_exp);  // Unmapped always acks
	assign wr       = req_free && wb_we_i && sel_ok;

	always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
		if (wb_rst_i) begin
			wb_ack_o <= 1'b0;
			wb_err_o <= 1'b0;
		end else begin
			wb_ack_o <= req_free && sel_ok;
			wb_err_o <= req_free && !sel_ok;
		end
	end

	// Control, divider and mask
	always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
		if (wb_rst_i) begin
			time_we    <= 1'b0;
			alm_we     <= 1'b0;
			int_en_o   <= 1'b0;
			div_val_o  <= DIV_RESET;
			alm_mask_o <= '0;
		end else begin
			if (wr && wb_adr_i == ADR_CON) begin
				time_we  <= wb_dat_i[CON_TIME_WE];
				alm_we   <= wb_dat_i[CON_ALM_WE];
				int_en_o <= wb_dat_i[CON_INT_EN];
			end
			if (wr && wb_adr_i == ADR_DIV)
				div_val_o <= wb_dat_i;
			if (wr && wb_adr_i == ADR_MASK)
				alm_mask_o <= wb_dat_i[6:0];
		end
	end

	// Alarm fields, locked unless alarm write enable is set
	always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
		if (wb_rst_i) begin
			alm_sec_o  <= '0;
			alm_min_o  <= '0;
			alm_hour_o <= '0;
			alm_day_o  <= '0;
			alm_date_o <= '0;
			alm_mon_o  <= '0;
			alm_year_o <= '0;
		end else if (wr && alm_we) begin
			case (wb_adr_i)
				ADR_ALM_SEC:  alm_sec_o  <= wb_dat_i[6:0];
				ADR_ALM_MIN:  alm_min_o  <= wb_dat_i[6:0];
				ADR_ALM_HOUR: alm_hour_o <= wb_dat_i[5:0];
				ADR_ALM_DAY:  alm_day_o  <= wb_dat_i[3:0];
				ADR_ALM_DATE: alm_date_o <= wb_dat_i[5:0];
				ADR_ALM_MON:  alm_mon_o  <= wb_dat_i[4:0];
				ADR_ALM_YEAR: alm_year_o <= wb_dat_i[15:0];
				default:      alm_sec_o  <= alm_sec_o;
			endcase
		end
	end

	// Calendar writes go straight to the counters
	always_comb begin
		cal_we_o = '0;
		if (wr && time_we) begin
			case (wb_adr_i)
				ADR_SEC:  cal_we_o[F_SEC]  = 1'b1;
				ADR_MIN:  cal_we_o[F_MIN]  = 1'b1;
				ADR_HOUR: cal_we_o[F_HOUR] = 1'b1;
				ADR_DAY:  cal_we_o[F_DAY]  = 1'b1;
				ADR_DATE: cal_we_o[F_DATE] = 1'b1;
				ADR_MON:  cal_we_o[F_MON]  = 1'b1;
				ADR_YEAR: cal_we_o[F_YEAR] = 1'b1;
				default:  cal_we_o = '0;
			endcase
		end
	end

	assign cal_wdat_o = wb_dat_i;
	assign div_load_o = wr && (wb_adr_i == ADR_DIV);  // Restarts the second

	always_comb begin
		case (wb_adr_i)
			ADR_SEC:      rd_data = wb_dat_t'(sec_i);
			ADR_MIN:      rd_data = wb_dat_t'(min_i);
			ADR_HOUR:     rd_data = wb_dat_t'(hour_i);
			ADR_DAY:      rd_data = wb_dat_t'(day_i);
			ADR_DATE:     rd_data = wb_dat_t'(date_i);
			ADR_MON:      rd_data = wb_dat_t'(mon_i);
			ADR_YEAR:     rd_data = wb_dat_t'(year_i);
			ADR_CON: begin
				rd_data              = '0;
				rd_data[CON_TIME_WE] = time_we;
				rd_data[CON_ALM_WE]  = alm_we;
				rd_data[CON_INT_EN]  = int_en_o;
			end
			ADR_DIV:      rd_data = div_val_o;
			ADR_MASK:     rd_data = wb_dat_t'(alm_mask_o);
			ADR_ALM_SEC:  rd_data = wb_dat_t'(alm_sec_o);
			ADR_ALM_MIN:  rd_data = wb_dat_t'(alm_min_o);
			ADR_ALM_HOUR: rd_data = wb_dat_t'(alm_hour_o);
			ADR_ALM_DAY:  rd_data = wb_dat_t'(alm_day_o);
			ADR_ALM_DATE: rd_data = wb_dat_t'(alm_date_o);
			ADR_ALM_MON:  rd_data = wb_dat_t'(alm_mon_o);
			ADR_ALM_YEAR: rd_data = wb_dat_t'(alm_year_o);
			default:      rd_data = '0;
		endcase
	end

	always_ff @(posedge wb_clk_i)
		wb_dat_o <= rd_data;  // Valid together with ack

	a_ack_err_excl: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
		!(wb_ack_o && wb_err_o));
	a_ack_gap: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
		wb_ack_o |=> !wb_ack_o);

endmodule

// File: source/rtc_divider.sv
/* One-second tick every div_val_i clock cycles. A value of 0 stops the clock */
`timescale 1ns/1ps

module rtc_divider import rtc_pkg::*; (
	input  logic wb_clk_i,
	input  logic wb_rst_i,
	input  div_t div_val_i,
	input  logic div_load_i,
	output logic tick_o
);

	div_t cnt;  // Runs 1 to div_val_i

	assign tick_o = (cnt == div_val_i);  // cnt never reaches 0

	always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
		if (wb_rst_i) begin
			cnt <= div_t'(1);
		end else if (div_load_i || tick_o) begin
			cnt <= div_t'(1);
		end else if (div_val_i != '0) begin
			cnt <= cnt + div_t'(1);
		end
	end

	// Halted divider stays silent
	a_no_tick_halted: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
		(div_val_i == '0) |-> !tick_o);

endmodule

// File: source/rtc_calendar.sv
/* BCD calendar, Gregorian leap years over 0000-9999.
   A field write in the tick cycle wins over the increment of that field only */
`timescale 1ns/1ps

module rtc_calendar import rtc_pkg::*; (
	input  logic       wb_clk_i,
	input  logic       wb_rst_i,
	input  logic       tick_i,
	input  logic [6:0] cal_we_i,
	input  wb_dat_t    cal_wdat_i,
	output sec_t       sec_o,
	output min_t       min_o,
	output hour_t      hour_o,
	output day_t       day_o,
	output date_t      date_o,
	output mon_t       mon_o,
	output year_t      year_o
);

	logic  c_min, c_hour, c_day, c_mon, c_year;  // Carry into each field
	logic  leap;
	date_t date_last;

	// Two BCD digits plus one
	function automatic logic [7:0] bcd_inc(input logic [7:0] v);
		if (v[3:0] == 4'h9)
			return {v[7:4] + 4'h1, 4'h0};
		return v + 8'h01;
	endfunction

	// Two BCD digits divisible by four
	function automatic logic bcd_div4(input logic [7:0] v);
		if (v[4])  // Odd tens
			return (v[3:0] == 4'h2) || (v[3:0] == 4'h6);
		return (v[3:0] == 4'h0) || (v[3:0] == 4'h4) || (v[3:0] == 4'h8);
	endfunction

	assign c_min  = tick_i && (sec_o == 7'h59);
	assign c_hour = c_min && (min_o == 7'h59);
	assign c_day  = c_hour && (hour_o == 6'h23);
	assign c_mon  = c_day && (date_o == date_last);
	assign c_year = c_mon && (mon_o == 5'h12);

	// Century years only count when the century is divisible by four
	assign leap = (year_o[7:0] == 8'h00) ? bcd_div4(year_o[15:8]) : bcd_div4(year_o[7:0]);

	always_comb begin
		case (mon_o)
			5'h02:                      date_last = leap ? 6'h29 : 6'h28;
			5'h04, 5'h06, 5'h09, 5'h11: date_last = 6'h30;
			default:                    date_last = 6'h31;
		endcase
	end

	always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
		if (wb_rst_i) begin
			sec_o  <= RST_SEC;
			min_o  <= RST_MIN;
			hour_o <= RST_HOUR;
			day_o  <= RST_DAY;
			date_o <= RST_DATE;
			mon_o  <= RST_MON;
			year_o <= RST_YEAR;
		end else begin
			if (cal_we_i[F_SEC])
				sec_o <= cal_wdat_i[6:0];
			else if (tick_i)
				sec_o <= c_min ? 7'h00 : sec_t'(bcd_inc(8'(sec_o)));

			if (cal_we_i[F_MIN])
				min_o <= cal_wdat_i[6:0];
			else if (c_min)
				min_o <= c_hour ? 7'h00 : min_t'(bcd_inc(8'(min_o)));

			if (cal_we_i[F_HOUR])
				hour_o <= cal_wdat_i[5:0];
			else if (c_hour)
				hour_o <= c_day ? 6'h00 : hour_t'(bcd_inc(8'(hour_o)));

			if (cal_we_i[F_DAY])
				day_o <= cal_wdat_i[3:0];
			else if (c_day)
				day_o <= (day_o == 4'h7) ? 4'h1 : day_o + 4'h1;

			if (cal_we_i[F_DATE])
				date_o <= cal_wdat_i[5:0];
			else if (c_day)
				date_o <= c_mon ? 6'h01 : date_t'(bcd_inc(8'(date_o)));

			if (cal_we_i[F_MON])
				mon_o <= cal_wdat_i[4:0];
			else if (c_mon)
				mon_o <= c_year ? 5'h01 : mon_t'(bcd_inc(8'(mon_o)));

			if (cal_we_i[F_YEAR]) begin
				year_o <= cal_wdat_i[15:0];
			end else if (c_year) begin
				if (year_o[7:0] == 8'h99)  // Hundreds carry
					year_o <= {bcd_inc(year_o[15:8]), 8'h00};
				else
					year_o <= {year_o[15:8], bcd_inc(year_o[7:0])};
			end
		end
	end

	// Counting keeps the seconds digit valid unless software writes it
	a_sec_digit: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
		(sec_o[3:0] <= 4'h9) && !cal_we_i[F_SEC] |=> (sec_o[3:0] <= 4'h9));

endmodule

// File: source/rtc_alarm.sv
/* Registered alarm. Level output while the masked fields match, so an empty
   mask with the interrupt enabled holds it high */
`timescale 1ns/1ps

module rtc_alarm import rtc_pkg::*; (
	input  logic       wb_clk_i,
	input  logic       wb_rst_i,
	input  sec_t       sec_i,
	input  min_t       min_i,
	input  hour_t      hour_i,
	input  day_t       day_i,
	input  date_t      date_i,
	input  mon_t       mon_i,
	input  year_t      year_i,
	input  sec_t       alm_sec_i,
	input  min_t       alm_min_i,
	input  hour_t      alm_hour_i,
	input  day_t       alm_day_i,
	input  date_t      alm_date_i,
	input  mon_t       alm_mon_i,
	input  year_t      alm_year_i,
	input  logic [6:0] alm_mask_i,
	input  logic       int_en_i,
	output logic       rtc_int_o
);

	logic [6:0] hit;  // Field matches or is masked off

	assign hit[F_SEC]  = !alm_mask_i[F_SEC]  || (sec_i  == alm_sec_i);
	assign hit[F_MIN]  = !alm_mask_i[F_MIN]  || (min_i  == alm_min_i);
	assign hit[F_HOUR] = !alm_mask_i[F_HOUR] || (hour_i == alm_hour_i);
	assign hit[F_DAY]  = !alm_mask_i[F_DAY]  || (day_i  == alm_day_i);
	assign hit[F_DATE] = !alm_mask_i[F_DATE] || (date_i == alm_date_i);
	assign hit[F_MON]  = !alm_mask_i[F_MON]  || (mon_i  == alm_mon_i);
	assign hit[F_YEAR] = !alm_mask_i[F_YEAR] || (year_i == alm_year_i);

	always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
		if (wb_rst_i)
			rtc_int_o <= 1'b0;
		else
			rtc_int_o <= int_en_i && (&hit);
	end

endmodule

// File: source/rtc_top.sv
/* Wishbone RTC on a single clock. DIV_RESET sets the cycles per second after
   reset, 0 keeps the calendar stopped until software loads the divider */
`timescale 1ns/1ps

module rtc_top import rtc_pkg::*; #(
	parameter div_t DIV_RESET = 32'd8
) (
	input  logic    wb_clk_i,
	input  logic    wb_rst_i,
	input  logic    wb_cyc_i,
	input  logic    wb_stb_i,
	input  logic    wb_we_i,
	input  wb_adr_t wb_adr_i,
	input  wb_sel_t wb_sel_i,
	input  wb_dat_t wb_dat_i,
	output wb_dat_t wb_dat_o,
	output logic    wb_ack_o,
	output logic    wb_err_o,
	output logic    rtc_int_o
);

	div_t       div_val;
	logic       div_load;
	logic       tick;
	logic [6:0] cal_we;
	wb_dat_t    cal_wdat;
	sec_t       sec, alm_sec;
	min_t       min, alm_min;
	hour_t      hour, alm_hour;
	day_t       day, alm_day;
	date_t      date, alm_date;
	mon_t       mon, alm_mon;
	year_t      year, alm_year;
	logic [6:0] alm_mask;
	logic       int_en;

	rtc_wb_regs #(
		.DIV_RESET(DIV_RESET)
	) i_regs (
		.wb_clk_i, .wb_rst_i, .wb_cyc_i, .wb_stb_i, .wb_we_i,
		.wb_adr_i, .wb_sel_i, .wb_dat_i, .wb_dat_o, .wb_ack_o, .wb_err_o,
		.sec_i(sec), .min_i(min), .hour_i(hour), .day_i(day),
		.date_i(date), .mon_i(mon), .year_i(year),
		.div_val_o(div_val), .div_load_o(div_load),
		.cal_we_o(cal_we), .cal_wdat_o(cal_wdat),
		.alm_sec_o(alm_sec), .alm_min_o(alm_min), .alm_hour_o(alm_hour),
		.alm_day_o(alm_day), .alm_date_o(alm_date), .alm_mon_o(alm_mon),
		.alm_year_o(alm_year), .alm_mask_o(alm_mask), .int_en_o(int_en)
	);

	rtc_divider i_div (
		.wb_clk_i, .wb_rst_i,
		.div_val_i(div_val), .div_load_i(div_load), .tick_o(tick)
	);

	rtc_calendar i_cal (
		.wb_clk_i, .wb_rst_i,
		.tick_i(tick), .cal_we_i(cal_we), .cal_wdat_i(cal_wdat),
		.sec_o(sec), .min_o(min), .hour_o(hour), .day_o(day),
		.date_o(date), .mon_o(mon), .year_o(year)
	);

	rtc_alarm i_alarm (
		.wb_clk_i, .wb_rst_i,
		.sec_i(sec), .min_i(min), .hour_i(hour), .day_i(day),
		.date_i(date), .mon_i(mon), .year_i(year),
		.alm_sec_i(alm_sec), .alm_min_i(alm_min), .alm_hour_i(alm_hour),
		.alm_day_i(alm_day), .alm_date_i(alm_date), .alm_mon_i(alm_mon),
		.alm_year_i(alm_year), .alm_mask_i(alm_mask), .int_en_i(int_en),
		.rtc_int_o
	);

endmodule

// File: test/tb_rtc.sv
/* Random register traffic and calendar checks against a model of the register map.
   The divider resets to 0, so the calendar only moves while a test has loaded it */
`timescale 1ns/1ps

module tb_rtc import rtc_pkg::*; ();

	logic        wb_clk_i, wb_rst_i, wb_cyc_i, wb_stb_i, wb_we_i;
	wb_adr_t     wb_adr_i;
	wb_sel_t     wb_sel_i;
	wb_dat_t     wb_dat_i, wb_dat_o;
	logic        wb_ack_o, wb_err_o, rtc_int_o;

	integer      seed = 60262;
	int          err_cnt, check_cnt, test_err;
	logic [31:0] m_con, m_div, m_mask;              // Model of the register map
	logic [15:0] m_cal[7], m_alm[7], nxt[7];        // BCD fields, nxt is one second later

	rtc_top #(.DIV_RESET(32'd0)) i_dut (
		.wb_clk_i, .wb_rst_i, .wb_cyc_i, .wb_stb_i, .wb_we_i,
		.wb_adr_i, .wb_sel_i, .wb_dat_i, .wb_dat_o, .wb_ack_o, .wb_err_o, .rtc_int_o
	);

	initial begin
		wb_clk_i = 1'b0;
		forever #4 wb_clk_i = ~wb_clk_i;
	end

	function automatic int rand_below(int n);
		return int'($unsigned($random(seed)) % 32'(n));
	endfunction

	function automatic logic [15:0] to_bcd(int v);
		return {4'(v / 1000 % 10), 4'(v / 100 % 10), 4'(v / 10 % 10), 4'(v % 10)};
	endfunction

	function automatic int from_bcd(logic [15:0] b);
		return b[15:12] * 1000 + b[11:8] * 100 + b[7:4] * 10 + b[3:0];
	endfunction

	function automatic logic [15:0] field_mask(int f);
		case (f)
			F_SEC, F_MIN:   return 16'h007f;
			F_HOUR, F_DATE: return 16'h003f;
			F_DAY:          return 16'h000f;
			F_MON:          return 16'h001f;
			default:        return 16'hffff;
		endcase
	endfunction

	function automatic logic [15:0] rand_field(int f);
		case (f)
			F_SEC, F_MIN: return to_bcd(rand_below(60));
			F_HOUR:       return to_bcd(rand_below(24));
			F_DAY:        return to_bcd(1 + rand_below(7));
			F_DATE:       return to_bcd(1 + rand_below(28));
			F_MON:        return to_bcd(1 + rand_below(12));
			default:      return to_bcd(1900 + rand_below(300));
		endcase
	endfunction

	function automatic int month_days(int mo, int y);
		if (mo == 2)
			return ((y % 4 == 0 && y % 100 != 0) || y % 400 == 0) ? 29 : 28;
		if (mo == 4 || mo == 6 || mo == 9 || mo == 11)
			return 30;
		return 31;
	endfunction

	function automatic logic is_mapped(wb_adr_t adr);
		return adr <= ADR_YEAR || adr == ADR_CON || adr == ADR_DIV ||
			(adr >= ADR_MASK && adr <= ADR_ALM_YEAR);
	endfunction

	// 0-6 calendar, 7 control, 8 divider, 9 mask, 10-16 alarm
	function automatic wb_adr_t mapped_adr(int idx);
		if (idx < 7)
			return wb_adr_t'(idx);
		if (idx == 7)
			return ADR_CON;
		if (idx == 8)
			return ADR_DIV;
		if (idx == 9)
			return ADR_MASK;
		return wb_adr_t'(ADR_ALM_SEC + 5'(idx - 10));
	endfunction

	function automatic wb_sel_t sel_for(wb_adr_t adr);
		if (adr == ADR_YEAR || adr == ADR_ALM_YEAR)
			return SEL_HALF;
		return (adr == ADR_DIV) ? SEL_WORD : SEL_BYTE;
	endfunction

	function automatic logic [31:0] expected_read(wb_adr_t adr);
		if (adr <= ADR_YEAR)
			return 32'(m_cal[int'(adr)]);
		if (adr == ADR_CON)
			return m_con & 32'h61;
		if (adr == ADR_DIV)
			return m_div;
		if (adr == ADR_MASK)
			return m_mask;
		if (adr >= ADR_ALM_SEC && adr <= ADR_ALM_YEAR)
			return 32'(m_alm[int'(adr - ADR_ALM_SEC)]);
		return 32'h0;  // Unmapped
	endfunction

	task automatic model_write(input wb_adr_t adr, input logic [31:0] dat);
		if (adr <= ADR_YEAR && m_con[CON_TIME_WE])
			m_cal[int'(adr)] = dat[15:0] & field_mask(int'(adr));
		else if (adr == ADR_CON)
			m_con = dat & 32'h61;
		else if (adr == ADR_DIV)
			m_div = dat;
		else if (adr == ADR_MASK)
			m_mask = dat & 32'h7f;
		else if (adr >= ADR_ALM_SEC && adr <= ADR_ALM_YEAR && m_con[CON_ALM_WE])
			m_alm[int'(adr - ADR_ALM_SEC)] = dat[15:0] & field_mask(int'(adr - ADR_ALM_SEC));
	endtask

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		check_cnt++;
		assert (got === exp) else begin
			$display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
			err_cnt++;
		end
	endtask

	task automatic check_true(input logic cond, input string what);
		check_cnt++;
		assert (cond) else begin
			$display("t=%0t %s", $time, what);
			err_cnt++;
		end
	endtask

	// One request, held until ack or err comes back
	task automatic bus_cycle(input logic we, input wb_adr_t adr, input wb_sel_t sel,
		input logic [31:0] dat, output logic [31:0] rdat, output logic ack, output logic err);
		int n;
		wb_cyc_i = 1'b1;
		wb_stb_i = 1'b1;
		wb_we_i  = we;
		wb_adr_i = adr;
		wb_sel_i = sel;
		wb_dat_i = dat;
		n = 0;
		do begin
			@(posedge wb_clk_i);
			#1;
			n++;
		end while (!wb_ack_o && !wb_err_o && n < 10);
		ack = wb_ack_o;
		err = wb_err_o;
		rdat = wb_dat_o;
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		wb_we_i  = 1'b0;
		check_true(ack || err, $sformatf("bus cycle to address %h got neither ack nor err", adr));
	endtask

	task automatic access(input logic we, input wb_adr_t adr, input wb_sel_t sel,
		input logic [31:0] dat);
		logic [31:0] rdat;
		logic ack, err;
		bus_cycle(we, adr, sel, dat, rdat, ack, err);
		check_true(ack && !err, $sformatf("access to address %h was not acknowledged", adr));
		if (we)
			model_write(adr, dat);
		else
			check_value($sformatf("wb_dat_o[adr %h]", adr), rdat, expected_read(adr));
	endtask

	task automatic write_reg(input wb_adr_t adr, input logic [31:0] dat);
		access(1'b1, adr, sel_for(adr), dat);
	endtask

	task automatic read_check(input wb_adr_t adr);
		access(1'b0, adr, sel_for(adr), 32'h0);
	endtask

	task automatic read_value(input wb_adr_t adr, output logic [31:0] v);
		logic ack, err;
		bus_cycle(1'b0, adr, sel_for(adr), 32'h0, v, ack, err);
	endtask

	// Calendar one second after m_cal, counted in binary
	task automatic compute_next();
		int s, mi, h, d, dt, mo, y;
		s = from_bcd(m_cal[F_SEC]) + 1;
		mi = from_bcd(m_cal[F_MIN]);
		h = from_bcd(m_cal[F_HOUR]);
		d = from_bcd(m_cal[F_DAY]);
		dt = from_bcd(m_cal[F_DATE]);
		mo = from_bcd(m_cal[F_MON]);
		y = from_bcd(m_cal[F_YEAR]);
		if (s == 60) begin
			s = 0;
			mi++;
		end
		if (mi == 60) begin
			mi = 0;
			h++;
		end
		if (h == 24) begin
			h = 0;
			d = d % 7 + 1;
			dt++;
		end
		if (dt > month_days(mo, y)) begin
			dt = 1;
			mo++;
		end
		if (mo == 13) begin
			mo = 1;
			y++;
		end
		nxt[F_SEC] = to_bcd(s);
		nxt[F_MIN] = to_bcd(mi);
		nxt[F_HOUR] = to_bcd(h);
		nxt[F_DAY] = to_bcd(d);
		nxt[F_DATE] = to_bcd(dt);
		nxt[F_MON] = to_bcd(mo);
		nxt[F_YEAR] = to_bcd(y);
	endtask

	task automatic finish_test(input int num, input string name);
		$display("test %0d %s: %0d errors", num, name, err_cnt - test_err);
		test_err = err_cnt;
	endtask

	initial begin
		#1_000_000;
		$display("simulation ran past its time limit");
		$display("TB FAILED");
		$finish;
	end

	initial begin
		int i, f, k, n, dt, mo, y;
		wb_adr_t adr;
		wb_sel_t sel;
		logic [31:0] dat, rdat;
		logic ack, err;
		logic [6:0] mask;
		logic [15:0] pre[7];
		wb_rst_i = 1'b1;
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		wb_we_i  = 1'b0;
		wb_adr_i = '0;
		wb_sel_i = '0;
		wb_dat_i = '0;
		m_con = 0;
		m_div = 0;
		m_mask = 0;
		for (f = 0; f < 7; f++)
			m_alm[f] = 16'h0;
		m_cal = '{16'h00, 16'h00, 16'h00, 16'h1, 16'h01, 16'h01, 16'h2000};
		repeat (5) @(posedge wb_clk_i);
		#1 wb_rst_i = 1'b0;

		for (i = 0; i < 150; i++) begin
			k = rand_below(11);
			case (k)
				0:                   adr = ADR_CON;
				1:                   adr = ADR_DIV;
				2:                   adr = ADR_MASK;
				3, 4, 5, 6, 7, 8, 9: adr = wb_adr_t'(ADR_ALM_SEC + 5'(k - 3));
				default: begin
					do adr = wb_adr_t'($random(seed)); while (is_mapped(adr));
				end
			endcase
			dat = $random(seed);
			if (adr == ADR_DIV)
				dat = dat | 32'h0001_0000;  // Too long to tick during this test
			sel = is_mapped(adr) ? sel_for(adr) : wb_sel_t'($random(seed));
			access(rand_below(2) == 1, adr, sel, dat);
		end
		write_reg(ADR_DIV, 32'h0);
		finish_test(1, "register readback");

		for (i = 0; i < 40; i++) begin
			adr = mapped_adr(rand_below(17));
			do sel = wb_sel_t'($random(seed)); while (sel == sel_for(adr));
			bus_cycle(rand_below(2) == 1, adr, sel, $random(seed), rdat, ack, err);
			check_true(err && !ack, $sformatf("select %b at address %h gave no lone err", sel, adr));
			read_check(adr);
		end
		finish_test(2, "select errors");

		write_reg(ADR_CON, 32'h0);
		for (f = 0; f < 7; f++) begin
			write_reg(wb_adr_t'(f), 32'(rand_field(f)));
			read_check(wb_adr_t'(f));
		end
		write_reg(ADR_CON, 32'h1);
		for (f = 0; f < 7; f++) begin
			write_reg(wb_adr_t'(f), 32'(rand_field(f)));
			read_check(wb_adr_t'(f));
		end
		finish_test(3, "calendar write gating");

		for (i = 0; i < 16; i++) begin
			k = (i < 10) ? i : rand_below(10);
			pre[F_SEC] = (i < 10 || rand_below(8) != 0) ? 16'h59 : rand_field(F_SEC);
			pre[F_MIN] = (i < 10 || rand_below(4) != 0) ? 16'h59 : rand_field(F_MIN);
			pre[F_HOUR] = (i < 10 || rand_below(4) != 0) ? 16'h23 : rand_field(F_HOUR);
			pre[F_DAY] = (rand_below(2) == 0) ? 16'h7 : rand_field(F_DAY);
			case (rand_below(4))
				0:       y = 2000;
				1:       y = 2100;
				2:       y = 2024;
				default: y = 2023;
			endcase
			case (k)
				0:       {dt, mo} = {32'd31, 32'd1};
				1:       {dt, mo, y} = {32'd28, 32'd2, 32'd2023};
				2:       {dt, mo, y} = {32'd28, 32'd2, 32'd2024};
				3:       {dt, mo, y} = {32'd29, 32'd2, 32'd2024};
				4:       {dt, mo, y} = {32'd28, 32'd2, 32'd2000};
				5:       {dt, mo, y} = {32'd29, 32'd2, 32'd2000};
				6:       {dt, mo, y} = {32'd28, 32'd2, 32'd2100};
				7:       {dt, mo} = {32'd30, 32'd4};
				8:       {dt, mo, y} = {32'd31, 32'd12, 32'd1999};
				default: {dt, mo} = {32'd30, 32'd11};
			endcase
			pre[F_DATE] = to_bcd(dt);
			pre[F_MON] = to_bcd(mo);
			pre[F_YEAR] = to_bcd(y);
			write_reg(ADR_DIV, 32'h0);
			write_reg(ADR_CON, 32'h1);
			for (f = 0; f < 7; f++)
				write_reg(wb_adr_t'(f), 32'(pre[f]));
			compute_next();
			write_reg(ADR_DIV, 32'd60);
			n = 0;
			do begin
				read_value(ADR_SEC, rdat);
				n++;
			end while (rdat == 32'(m_cal[F_SEC]) && n < 100);
			check_true(rdat != 32'(m_cal[F_SEC]), "seconds did not advance after loading the divider");
			for (f = 0; f < 7; f++) begin
				m_cal[f] = nxt[f];
				read_check(wb_adr_t'(f));
			end
		end
		write_reg(ADR_DIV, 32'h0);
		finish_test(4, "rollover");

		// Seconds always masked, so the match can only come from the tick
		mask = 7'($random(seed)) | 7'b1;
		write_reg(ADR_CON, 32'h20);
		compute_next();
		for (f = 0; f < 7; f++)
			write_reg(wb_adr_t'(ADR_ALM_SEC + 5'(f)), 32'(nxt[f]));
		write_reg(ADR_MASK, 32'(mask));
		write_reg(ADR_CON, 32'h60);
		write_reg(ADR_DIV, 32'd60);
		n = 0;
		while (!rtc_int_o && n < 200) begin
			@(posedge wb_clk_i);
			#1;
			n++;
		end
		check_true(rtc_int_o, "rtc_int_o did not rise within 200 cycles");
		for (f = 0; f < 7; f++) begin
			m_cal[f] = nxt[f];
			if (mask[f]) begin
				read_value(wb_adr_t'(f), rdat);
				check_value($sformatf("calendar field %0d", f), rdat, 32'(m_alm[f]));
			end
		end
		write_reg(ADR_DIV, 32'h0);
		write_reg(ADR_CON, 32'h20);  // Interrupt disabled
		compute_next();
		for (f = 0; f < 7; f++)
			write_reg(wb_adr_t'(ADR_ALM_SEC + 5'(f)), 32'(nxt[f]));
		write_reg(ADR_DIV, 32'd60);
		for (n = 0; n < 70; n++) begin
			@(posedge wb_clk_i);
			#1;
			check_value("rtc_int_o", 32'(rtc_int_o), 32'h0);
		end
		write_reg(ADR_DIV, 32'h0);
		for (f = 0; f < 7; f++)
			m_cal[f] = nxt[f];
		finish_test(5, "alarm");

		$display("5 tests, %0d checks, %0d errors", check_cnt, err_cnt);
		if (err_cnt == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

// File: rtc.f
source/rtc_pkg.sv
source/rtc_wb_regs.sv
source/rtc_divider.sv
source/rtc_calendar.sv
source/rtc_alarm.sv
source/rtc_top.sv
test/tb_rtc.sv

// File: run_sim.sh
#!/bin/sh
# Build the RTC testbench with Verilator, run it and scan the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_rtc -f rtc.f -o tb_rtc

./obj_dir/tb_rtc > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log

if grep -q "TB FAILED" sim.log; then
	exit 1
fi
exit 0
